//--- include/spi_reg_consts.svh
`ifndef SPI_REG_CONSTS_SVH
`define SPI_REG_CONSTS_SVH

// Serial framing sizes
`define SPI_BYTE_W     8
`define SPI_WORD_BYTES 8
`define SPI_WORD_W     64

// Register file geometry
`define REG_COUNT  8
`define REG_ADDR_W 3

// Opcodes carried in the first byte of a command word
`define OP_WRITE 8'h01
`define OP_READ  8'h02

// Status byte of a response word
`define ST_OK    8'h00
`define ST_ERROR 8'hEE

`endif

//--- rtl/spi_link_pkg.sv
`include "spi_reg_consts.svh"

// Types seen by the serial link layer
package spi_link_pkg;

  // One byte as it moves on copi or cipo
  // MSB goes first on the wire
  typedef logic [`SPI_BYTE_W-1:0] spi_byte_t;

  // Slot of a byte inside one 64-bit word
  // Slot 0 is the first byte of a frame
  typedef logic [$clog2(`SPI_WORD_BYTES)-1:0] byte_pos_t;

endpackage

//--- rtl/spi_cmd_pkg.sv
`include "spi_reg_consts.svh"

// Types of the command layer
package spi_cmd_pkg;

  // Width of one register
  typedef logic [31:0] reg_data_t;

  // Received word seen as a command
  // Opcode sits in the low byte, so it is the first byte on the wire
  typedef struct packed {
    reg_data_t   data;
    logic [15:0] reserved;
    logic [7:0]  addr;
    logic [7:0]  opcode;
  } cmd_fields_t;

  // Response word, status byte leaves first
  typedef struct packed {
    reg_data_t   data;
    logic [15:0] reserved;
    logic [7:0]  addr;
    logic [7:0]  status;
  } resp_fields_t;

  // One 64-bit word with its two decodings
  typedef union packed {
    logic [`SPI_WORD_W-1:0] raw;
    cmd_fields_t            cmd;
    resp_fields_t           resp;
  } spi_word_u;

endpackage

//--- rtl/spi_byte_link.sv
`timescale 1ns/1ps
`include "spi_reg_consts.svh"

module spi_byte_link
  import spi_link_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      sck,
  input  logic      cs_n,
  input  logic      copi,
  input  spi_byte_t tx_byte,
  output logic      cipo,
  output spi_byte_t rx_byte,
  output logic      byte_valid,
  output logic      frame_active
);

  // Pin synchronizers, bit 0 is the newest sample
  logic [2:0] sck_sync;
  logic [2:0] cs_sync;
  logic [2:0] copi_sync;

  logic sck_rise;
  logic sck_fall;

  // Receive count goes up, transmit index goes down from bit 7
  logic [2:0] rx_cnt;
  logic [2:0] tx_idx;

  // First seven bits of the byte being received
  logic [`SPI_BYTE_W-2:0] rx_shift;

  // Edges seen between the two oldest sck samples
  assign sck_rise = (sck_sync[2:1] == 2'b01);
  assign sck_fall = (sck_sync[2:1] == 2'b10);

  assign frame_active = ~cs_sync[2];

  // Current transmit bit, held low outside a frame
  assign cipo = frame_active & tx_byte[tx_idx];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sck_sync   <= 3'b000;
      // Start deselected
      cs_sync    <= 3'b111;
      copi_sync  <= 3'b000;
      rx_cnt     <= 3'd0;
      tx_idx     <= 3'd7;
      byte_valid <= 1'b0;
    end else begin
      sck_sync   <= {sck_sync[1:0], sck};
      cs_sync    <= {cs_sync[1:0], cs_n};
      copi_sync  <= {copi_sync[1:0], copi};
      byte_valid <= 1'b0;
      if (frame_active) begin
        if (sck_rise) begin
          rx_cnt     <= rx_cnt + 3'd1;
          // Eighth bit completes the byte
          byte_valid <= (rx_cnt == 3'd7);
        end
        // Wraps back to 7 for the next byte
        if (sck_fall) begin
          tx_idx <= tx_idx - 3'd1;
        end
      end else begin
        // Interrupted transfer starts over cleanly
        rx_cnt <= 3'd0;
        tx_idx <= 3'd7;
      end
    end
  end

  // Data path, MSB first
  always_ff @(posedge clk) begin
    if (frame_active && sck_rise) begin
      rx_shift <= {rx_shift[`SPI_BYTE_W-3:0], copi_sync[2]};
      if (rx_cnt == 3'd7) begin
        rx_byte <= {rx_shift, copi_sync[2]};
      end
    end
  end

endmodule

//--- rtl/spi_word_assembler.sv
`timescale 1ns/1ps
`include "spi_reg_consts.svh"

module spi_word_assembler
  import spi_link_pkg::*;
  import spi_cmd_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  spi_byte_t rx_byte,
  input  logic      byte_valid,
  input  logic      frame_active,
  input  spi_word_u resp_word,
  output spi_byte_t tx_byte,
  output spi_word_u rx_word,
  output logic      word_valid
);

  // Slot of the byte now on the wire, both directions
  byte_pos_t byte_pos;

  // Response leaves in the same little-endian order
  assign tx_byte = resp_word.raw[byte_pos*`SPI_BYTE_W +: `SPI_BYTE_W];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      byte_pos   <= '0;
      word_valid <= 1'b0;
    end else begin
      // Last byte of the word has landed
      word_valid <= byte_valid && (byte_pos == byte_pos_t'(`SPI_WORD_BYTES - 1));
      if (!frame_active) begin
        // Each frame starts again at slot 0
        byte_pos <= '0;
      end else if (byte_valid) begin
        // Wraps to 0 after the eighth byte
        byte_pos <= byte_pos + 1'b1;
      end
    end
  end

  // New bytes enter at the top
  // First byte drifts down to bits 7:0 after eight shifts
  always_ff @(posedge clk) begin
    if (byte_valid) begin
      rx_word.raw <= {rx_byte, rx_word.raw[`SPI_WORD_W-1:`SPI_BYTE_W]};
    end
  end

endmodule

//--- rtl/spi_cmd_regfile.sv
`timescale 1ns/1ps
`include "spi_reg_consts.svh"

module spi_cmd_regfile
  import spi_cmd_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  spi_word_u rx_word,
  input  logic      word_valid,
  output spi_word_u resp_word,
  output logic      cmd_error
);

  reg_data_t regs [`REG_COUNT];

  // Command view of the received word
  cmd_fields_t            cmd;
  logic [`REG_ADDR_W-1:0] reg_idx;
  logic                   addr_ok;
  logic                   do_write;
  logic                   do_read;
  spi_word_u              resp_next;

  assign cmd      = rx_word.cmd;
  assign reg_idx  = cmd.addr[`REG_ADDR_W-1:0];
  // Full 8-bit address checked, upper bits must be zero
  assign addr_ok  = (cmd.addr < `REG_COUNT);
  assign do_write = addr_ok && (cmd.opcode == `OP_WRITE);
  assign do_read  = addr_ok && (cmd.opcode == `OP_READ);

  // Response built through the response view
  always_comb begin
    resp_next           = '0;
    resp_next.resp.addr = cmd.addr;
    if (do_write) begin
      // Echo of the data written
      resp_next.resp.status = `ST_OK;
      resp_next.resp.data   = cmd.data;
    end else if (do_read) begin
      resp_next.resp.status = `ST_OK;
      resp_next.resp.data   = regs[reg_idx];
    end else begin
      // Bad opcode or address, data stays zero
      resp_next.resp.status = `ST_ERROR;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `REG_COUNT; i++) begin
        regs[i] <= '0;
      end
      resp_word <= '0;
      cmd_error <= 1'b0;
    end else begin
      cmd_error <= 1'b0;
      if (word_valid) begin
        // Held until the next word
        resp_word <= resp_next;
        cmd_error <= !(do_write || do_read);
        if (do_write) begin
          regs[reg_idx] <= cmd.data;
        end
      end
    end
  end

endmodule

//--- rtl/spi_reg_top.sv
`timescale 1ns/1ps

module spi_reg_top
  import spi_link_pkg::*;
  import spi_cmd_pkg::*;
(
  input  logic clk,
  input  logic rst_n,
  input  logic sck,
  input  logic cs_n,
  input  logic copi,
  output logic cipo,
  output logic word_valid,
  output logic cmd_error
);

  // Byte level link
  spi_byte_t rx_byte;
  spi_byte_t tx_byte;
  logic      byte_valid;
  logic      frame_active;

  // Word level, one command in and one response out
  spi_word_u rx_word;
  spi_word_u resp_word;

  spi_byte_link u_byte_link (
    .clk          (clk),
    .rst_n        (rst_n),
    .sck          (sck),
    .cs_n         (cs_n),
    .copi         (copi),
    .tx_byte      (tx_byte),
    .cipo         (cipo),
    .rx_byte      (rx_byte),
    .byte_valid   (byte_valid),
    .frame_active (frame_active)
  );

  spi_word_assembler u_word_assembler (
    .clk          (clk),
    .rst_n        (rst_n),
    .rx_byte      (rx_byte),
    .byte_valid   (byte_valid),
    .frame_active (frame_active),
    .resp_word    (resp_word),
    .tx_byte      (tx_byte),
    .rx_word      (rx_word),
    .word_valid   (word_valid)
  );

  spi_cmd_regfile u_cmd_regfile (
    .clk        (clk),
    .rst_n      (rst_n),
    .rx_word    (rx_word),
    .word_valid (word_valid),
    .resp_word  (resp_word),
    .cmd_error  (cmd_error)
  );

endmodule

//--- tests/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk,
  output logic rst_n
);

  // 8 ns period
  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Reset held for 16 rising edges, released 1 ns after an edge
  initial begin
    rst_n = 1'b0;
    repeat (16) @(posedge clk);
    #1 rst_n = 1'b1;
  end

endmodule

//--- tests/spi_reg_assertions.sv
`timescale 1ns/1ps

module spi_reg_assertions (
  input logic clk,
  input logic rst_n,
  input logic cs_n,
  input logic cipo,
  input logic byte_valid,
  input logic frame_active,
  input logic word_valid,
  input logic cmd_error
);

  // Count of failed assertions
  int fail_count = 0;

  // A byte only completes inside a frame
  byte_in_frame: assert property (@(posedge clk) disable iff (!rst_n)
    byte_valid |-> frame_active)
  else begin
    $error("byte_valid high while no frame is active");
    fail_count = fail_count + 1;
  end

  // Word strobe comes right after the last byte strobe
  word_after_byte: assert property (@(posedge clk) disable iff (!rst_n)
    word_valid |-> $past(byte_valid))
  else begin
    $error("word_valid without byte_valid one cycle before");
    fail_count = fail_count + 1;
  end

  // Error pulse is exactly one cycle behind its word
  error_after_word: assert property (@(posedge clk) disable iff (!rst_n)
    cmd_error |-> $past(word_valid))
  else begin
    $error("cmd_error without word_valid one cycle before");
    fail_count = fail_count + 1;
  end

  // Deselected long enough to pass the synchronizer, so cipo must be low
  cipo_idle_low: assert property (@(posedge clk) disable iff (!rst_n)
    (cs_n && $past(cs_n, 1) && $past(cs_n, 2) && $past(cs_n, 3)) |-> !cipo)
  else begin
    $error("cipo high while cs_n is high");
    fail_count = fail_count + 1;
  end

endmodule

bind spi_reg_top spi_reg_assertions u_assertions (
  .clk          (clk),
  .rst_n        (rst_n),
  .cs_n         (cs_n),
  .cipo         (cipo),
  .byte_valid   (byte_valid),
  .frame_active (frame_active),
  .word_valid   (word_valid),
  .cmd_error    (cmd_error)
);

//--- tests/spi_reg_tb.sv
`timescale 1ns/1ps
`include "spi_reg_consts.svh"

module spi_reg_tb
  import spi_cmd_pkg::*;
();

  localparam int NUM_ROWS    = 26;
  localparam int ABORT_BITS  = 20;
  // One frame is about 530 clk, plus the closing frame
  localparam int CYCLE_LIMIT = (NUM_ROWS + 1) * 620 + 2000;

  logic clk, rst_n, sck, cs_n, copi;
  logic cipo, word_valid, cmd_error;

  // Stimulus table, one frame per row
  logic [7:0] tbl_op   [NUM_ROWS];
  logic [7:0] tbl_addr [NUM_ROWS];
  reg_data_t  tbl_data [NUM_ROWS];
  int         tbl_bits [NUM_ROWS];
  spi_word_u  tbl_resp [NUM_ROWS];
  logic       tbl_err  [NUM_ROWS];

  // Reference copy of the register file
  reg_data_t model_regs [`REG_COUNT];
  int seed        = 32'h21a35e5f;
  int cycle_count = 0;
  int wv_count    = 0;
  int err_count   = 0;

  tb_clk_gen u_clk_gen (.clk(clk), .rst_n(rst_n));

  spi_reg_top u_spi_reg_top (
    .clk        (clk),
    .rst_n      (rst_n),
    .sck        (sck),
    .cs_n       (cs_n),
    .copi       (copi),
    .cipo       (cipo),
    .word_valid (word_valid),
    .cmd_error  (cmd_error)
  );

  task automatic stop_on_error(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic check_word(input string name, input spi_word_u exp, input spi_word_u act);
    if (act !== exp) begin
      stop_on_error($sformatf("Mismatch at %0t: %s expected %h actual %h",
                              $time, name, exp.raw, act.raw));
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      stop_on_error($sformatf("Mismatch at %0t: %s expected %b actual %b",
                              $time, name, exp, act));
    end
  endtask

  // Strobe counters, read 1 ns after the edge
  always @(posedge clk) begin
    if (word_valid === 1'b1) wv_count <= wv_count + 1;
    if (cmd_error === 1'b1) err_count <= err_count + 1;
  end

  // Watchdog
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      stop_on_error("Timeout: the test sequence did not finish within the cycle limit");
    end
  end

  // Step n edges, then 1 ns into the cycle
  task automatic wait_clk(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  task automatic set_row(input int r, input logic [7:0] op, input logic [7:0] addr,
                         input int bits);
    tbl_op[r]   = op;
    tbl_addr[r] = addr;
    tbl_data[r] = $random(seed);
    tbl_bits[r] = bits;
  endtask

  task automatic fill_table();
    // Never written yet, reads zero
    set_row(0, `OP_READ, 8'd5, `SPI_WORD_W);
    for (int i = 0; i < `REG_COUNT; i++) begin
      set_row(1 + i, `OP_WRITE, 8'(i), `SPI_WORD_W);
    end
    // Overwrite, readback must see the later value
    set_row(9, `OP_WRITE, 8'd2, `SPI_WORD_W);
    for (int i = 0; i < `REG_COUNT; i++) begin
      set_row(10 + i, `OP_READ, 8'(i), `SPI_WORD_W);
    end
    set_row(18, 8'h7F, 8'd1, `SPI_WORD_W);
    set_row(19, `OP_READ, 8'd1, `SPI_WORD_W);
    // Address 8 aliases register 0 if the upper bits were ignored
    set_row(20, `OP_WRITE, 8'h08, `SPI_WORD_W);
    set_row(21, `OP_READ, 8'hC3, `SPI_WORD_W);
    set_row(22, `OP_READ, 8'd0, `SPI_WORD_W);
    // Frame cut after 20 bits
    set_row(23, `OP_WRITE, 8'd4, ABORT_BITS);
    set_row(24, `OP_READ, 8'd4, `SPI_WORD_W);
    set_row(25, `OP_WRITE, 8'd4, `SPI_WORD_W);
  endtask

  // Expected response and error of each row
  task automatic build_expected();
    logic addr_ok;
    for (int i = 0; i < `REG_COUNT; i++) model_regs[i] = '0;
    for (int r = 0; r < NUM_ROWS; r++) begin
      addr_ok = (tbl_addr[r] < `REG_COUNT);
      tbl_resp[r] = '0;
      tbl_resp[r].resp.addr = tbl_addr[r];
      tbl_err[r] = 1'b0;
      if (tbl_bits[r] < `SPI_WORD_W) begin
        // Never decoded
        tbl_resp[r] = '0;
      end else if (addr_ok && tbl_op[r] == `OP_WRITE) begin
        tbl_resp[r].resp.status = `ST_OK;
        tbl_resp[r].resp.data   = tbl_data[r];
        model_regs[tbl_addr[r][2:0]] = tbl_data[r];
      end else if (addr_ok && tbl_op[r] == `OP_READ) begin
        tbl_resp[r].resp.status = `ST_OK;
        tbl_resp[r].resp.data   = model_regs[tbl_addr[r][2:0]];
      end else begin
        tbl_resp[r].resp.status = `ST_ERROR;
        tbl_err[r] = 1'b1;
      end
    end
  endtask

  // SPI mode 0 controller, bytes little endian, MSB first in a byte
  task automatic run_frame(input spi_word_u tx, input int nbits,
                           output spi_word_u seen, output spi_word_u mask);
    int bit_idx;
    seen = '0;
    mask = '0;
    wait_clk(1);
    cs_n = 1'b0;
    wait_clk(6);
    for (int k = 0; k < nbits; k++) begin
      bit_idx = (k / 8) * 8 + 7 - (k % 8);
      copi = tx.raw[bit_idx];
      wait_clk(4);
      sck = 1'b1;
      seen.raw[bit_idx] = cipo;
      mask.raw[bit_idx] = 1'b1;
      wait_clk(4);
      sck = 1'b0;
    end
    copi = 1'b0;
    cs_n = 1'b1;
    wait_clk(10);
  endtask

  initial begin
    spi_word_u cmd, seen, mask, exp_seen, pending;
    int nbits, wv_before, err_before;
    logic exp_err;
    sck  = 1'b0;
    cs_n = 1'b1;
    copi = 1'b0;
    fill_table();
    build_expected();
    @(posedge rst_n);
    wait_clk(2);
    check_bit("cipo", 1'b0, cipo);
    check_bit("word_valid", 1'b0, word_valid);
    check_bit("cmd_error", 1'b0, cmd_error);
    // Response register is zero out of reset
    pending = '0;
    // Last pass is the closing read of register 0
    for (int r = 0; r <= NUM_ROWS; r++) begin
      cmd = '0;
      cmd.cmd.opcode = (r < NUM_ROWS) ? tbl_op[r] : `OP_READ;
      cmd.cmd.addr   = (r < NUM_ROWS) ? tbl_addr[r] : 8'd0;
      cmd.cmd.data   = (r < NUM_ROWS) ? tbl_data[r] : '0;
      nbits   = (r < NUM_ROWS) ? tbl_bits[r] : `SPI_WORD_W;
      exp_err = (r < NUM_ROWS) && tbl_err[r];
      wv_before  = wv_count;
      err_before = err_count;
      run_frame(cmd, nbits, seen, mask);
      // Previous response, only the bits clocked out
      exp_seen.raw = pending.raw & mask.raw;
      check_word($sformatf("cipo response in frame %0d", r), exp_seen, seen);
      if (wv_count - wv_before > 1 || err_count - err_before > 1) begin
        stop_on_error($sformatf("Frame %0d produced more than one strobe pulse", r));
      end
      check_bit("word_valid", nbits == `SPI_WORD_W, wv_count != wv_before);
      check_bit("cmd_error", exp_err, err_count != err_before);
      if (r < NUM_ROWS && nbits == `SPI_WORD_W) pending = tbl_resp[r];
    end
    if (u_spi_reg_top.u_assertions.fail_count == 0) begin
      $display("Simulation completed successfully");
      $finish;
    end else begin
      stop_on_error("One or more assertions failed during the run");
    end
  end

endmodule

//--- tb.f
+incdir+include
rtl/spi_link_pkg.sv
rtl/spi_cmd_pkg.sv
rtl/spi_byte_link.sv
rtl/spi_word_assembler.sv
rtl/spi_cmd_regfile.sv
rtl/spi_reg_top.sv
tests/tb_clk_gen.sv
tests/spi_reg_assertions.sv
tests/spi_reg_tb.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := spi_reg_tb
FILELIST   := tb.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing --assert -Wall
SIM_FLAGS  := --binary --timing --assert
PASS_MSG   := Simulation completed successfully

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# The run passes only if the pass message shows up in its output
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
